//--- common/avr_consts.svh
`ifndef AVR_CONSTS_SVH
`define AVR_CONSTS_SVH

// Data path byte width
`define AVR_DATA_W 8
// Program and data address width
`define AVR_ADDR_W 16
// General purpose register count
`define AVR_NREGS 32
// Register index width
`define AVR_RIDX_W 5
// Low register of the X pair (r27:r26)
`define AVR_BASE_X 26

// Status register bit positions
`define AVR_SREG_C 0
`define AVR_SREG_Z 1
`define AVR_SREG_N 2
`define AVR_SREG_V 3
`define AVR_SREG_S 4
`define AVR_SREG_H 5

// Opcode field positions
// Rd sits in bits 8..4 of most formats
`define AVR_RD_MSB 8
`define AVR_RD_LSB 4
// High bit of Rr, also the ST/LD select
`define AVR_RR_HI 9
// Clear for BRBS, set for BRBC
`define AVR_BRBC_BIT 10

`endif

//--- common/avr_pkg.sv
`include "avr_consts.svh"

package avr_pkg;

	// Operation codes for the 8-bit ALU
	typedef enum logic [3:0] {
		ALU_MOVE,
		ALU_ADD,
		ALU_ADC,
		ALU_SUB,
		ALU_SBC,
		ALU_AND,
		ALU_OR,
		ALU_EOR,
		ALU_LSR,
		ALU_ASR,
		ALU_ROR
	} alu_op_e;

	// AVR status register, I in bit 7 down to C in bit 0
	typedef struct packed {
		logic i;
		logic t;
		logic h;
		logic s;
		logic v;
		logic n;
		logic z;
		logic c;
	} sreg_t;

	// Source of the ALU A input
	typedef enum logic [1:0] {
		A_RD,
		A_IMM,
		A_LOAD,
		A_X
	} operand_sel_e;

	// Everything the core needs for one instruction cycle
	typedef struct packed {
		alu_op_e                 alu_op;
		operand_sel_e            a_sel;
		logic                    b_is_imm;
		logic                    b_is_one;
		logic [`AVR_DATA_W-1:0]  imm;
		// Read ports and write target
		logic [`AVR_RIDX_W-1:0]  ra_idx;
		logic [`AVR_RIDX_W-1:0]  rb_idx;
		logic [`AVR_RIDX_W-1:0]  dest;
		logic                    store;
		logic                    store_word;
		logic                    sreg_update;
		// INC and DEC leave C and H alone
		logic                    keep_ch;
		// Forces the ALU carry input high
		logic                    carry_one;
		logic                    mem_read;
		logic                    mem_write;
		logic                    x_post_inc;
		logic                    next_cycle;
		logic                    branch;
		// Clear for an unconditional jump
		logic                    cond_en;
		logic [`AVR_ADDR_W-1:0]  offset;
		logic [2:0]              cond_bit;
		logic                    cond_set;
	} decode_t;

	// Data memory request
	typedef struct packed {
		logic [`AVR_ADDR_W-1:0] addr;
		logic [`AVR_DATA_W-1:0] wdata;
		logic                   wen;
		logic                   ren;
	} data_req_t;

endpackage

//--- rtl/avr_alu.sv
`include "avr_consts.svh"

module avr_alu (
	input  avr_pkg::alu_op_e       op,
	input  logic [`AVR_DATA_W-1:0] a,
	input  logic [`AVR_DATA_W-1:0] b,
	input  logic                   carry_in,
	input  avr_pkg::sreg_t         sreg_in,
	output logic [`AVR_DATA_W-1:0] result,
	output avr_pkg::sreg_t         sreg_out
);
	// One extra bit holds carry or borrow
	logic [`AVR_DATA_W:0] sum;
	logic [`AVR_DATA_W:0] diff;
	logic                 use_carry;

	always_comb begin
		// Only ADC and SBC chain the carry
		use_carry = (op == avr_pkg::ALU_ADC || op == avr_pkg::ALU_SBC) ? carry_in : 1'b0;
		sum = {1'b0, a} + {1'b0, b} + {{`AVR_DATA_W{1'b0}}, use_carry};
		diff = {1'b0, a} - {1'b0, b} - {{`AVR_DATA_W{1'b0}}, use_carry};

		// MOVE falls through with A and the old flags
		result = a;
		sreg_out = sreg_in;

		case (op)
			avr_pkg::ALU_ADD,
			avr_pkg::ALU_ADC: begin
				result = sum[`AVR_DATA_W-1:0];
				// Carry out of bit 3
				sreg_out.h = (a[3] & b[3]) | (b[3] & ~result[3]) | (~result[3] & a[3]);
				// Same-sign operands, other-sign result
				sreg_out.v = (a[7] & b[7] & ~result[7]) | (~a[7] & ~b[7] & result[7]);
				sreg_out.c = sum[`AVR_DATA_W];
			end
			avr_pkg::ALU_SUB,
			avr_pkg::ALU_SBC: begin
				result = diff[`AVR_DATA_W-1:0];
				// Borrow from bit 4
				sreg_out.h = (~a[3] & b[3]) | (b[3] & result[3]) | (result[3] & ~a[3]);
				sreg_out.v = (a[7] & ~b[7] & ~result[7]) | (~a[7] & b[7] & result[7]);
				sreg_out.c = diff[`AVR_DATA_W];
			end
			avr_pkg::ALU_AND: begin
				result = a & b;
				sreg_out.v = 1'b0;
				sreg_out.c = carry_in;
			end
			avr_pkg::ALU_OR: begin
				result = a | b;
				sreg_out.v = 1'b0;
				sreg_out.c = carry_in;
			end
			avr_pkg::ALU_EOR: begin
				result = a ^ b;
				sreg_out.v = 1'b0;
				// COM comes through here with carry_in forced high
				sreg_out.c = carry_in;
			end
			avr_pkg::ALU_LSR: begin
				result = {1'b0, a[7:1]};
				sreg_out.c = a[0];
				sreg_out.v = result[7] ^ a[0];
			end
			avr_pkg::ALU_ASR: begin
				result = {a[7], a[7:1]};
				sreg_out.c = a[0];
				sreg_out.v = result[7] ^ a[0];
			end
			avr_pkg::ALU_ROR: begin
				result = {carry_in, a[7:1]};
				sreg_out.c = a[0];
				sreg_out.v = result[7] ^ a[0];
			end
			default: begin
			end
		endcase

		if (op != avr_pkg::ALU_MOVE) begin
			sreg_out.n = result[7];
			// SBC only keeps Z if it was already set
			if (op == avr_pkg::ALU_SBC)
				sreg_out.z = (result == '0) & sreg_in.z;
			else
				sreg_out.z = (result == '0);
			sreg_out.s = sreg_out.n ^ sreg_out.v;
		end
	end

endmodule

//--- rtl/avr_regfile.sv
`include "avr_consts.svh"

module avr_regfile (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [`AVR_RIDX_W-1:0] rd_idx,
	input  logic [`AVR_RIDX_W-1:0] rr_idx,
	output logic [`AVR_DATA_W-1:0] rd_val,
	output logic [`AVR_DATA_W-1:0] rr_val,
	output logic [`AVR_ADDR_W-1:0] x_val,
	input  logic                   wen,
	input  logic                   wword,
	input  logic [`AVR_RIDX_W-1:0] widx,
	input  logic [`AVR_ADDR_W-1:0] wdata
);
	// r0..r31 in flops
	logic [`AVR_DATA_W-1:0] regs [`AVR_NREGS];

	// Asynchronous reads
	assign rd_val = regs[rd_idx];
	assign rr_val = regs[rr_idx];

	// X pointer straight off r27:r26
	assign x_val = {regs[`AVR_BASE_X+1], regs[`AVR_BASE_X]};

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `AVR_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wen) begin
			if (wword) begin
				// Pair write, forced to even/odd alignment
				regs[{widx[`AVR_RIDX_W-1:1], 1'b0}] <= wdata[`AVR_DATA_W-1:0];
				regs[{widx[`AVR_RIDX_W-1:1], 1'b1}] <= wdata[`AVR_ADDR_W-1:`AVR_DATA_W];
			end else begin
				regs[widx] <= wdata[`AVR_DATA_W-1:0];
			end
		end
	end

endmodule

//--- decode/avr_decode.sv
`include "avr_consts.svh"

module avr_decode (
	input  logic [15:0]       opcode,
	input  logic              cycle,
	output avr_pkg::decode_t  dec
);
	logic [`AVR_RIDX_W-1:0] op_rd;
	logic [`AVR_RIDX_W-1:0] op_rr;
	// Immediate forms only reach r16..r31
	logic [`AVR_RIDX_W-1:0] op_rdi;
	logic [`AVR_DATA_W-1:0] op_k;
	logic [`AVR_ADDR_W-1:0] simm7;
	logic [`AVR_ADDR_W-1:0] simm12;

	always_comb begin
		op_rd = opcode[`AVR_RD_MSB:`AVR_RD_LSB];
		op_rr = {opcode[`AVR_RR_HI], opcode[3:0]};
		op_rdi = {1'b1, opcode[7:4]};
		op_k = {opcode[11:8], opcode[3:0]};
		simm7 = {{9{opcode[9]}}, opcode[9:3]};
		simm12 = {{4{opcode[11]}}, opcode[11:0]};

		// Anything not matched below runs as a NOP
		dec = '0;
		dec.alu_op = avr_pkg::ALU_MOVE;
		dec.a_sel = avr_pkg::A_RD;
		dec.ra_idx = op_rd;
		dec.rb_idx = op_rr;
		dec.dest = op_rd;

		casez (opcode)
			// CPC, SBC, ADD
			16'b0000_01??_????_????: begin
				dec.alu_op = avr_pkg::ALU_SBC;
				dec.sreg_update = 1'b1;
			end
			16'b0000_10??_????_????: begin
				dec.alu_op = avr_pkg::ALU_SBC;
				dec.store = 1'b1;
				dec.sreg_update = 1'b1;
			end
			16'b0000_11??_????_????: begin
				dec.alu_op = avr_pkg::ALU_ADD;
				dec.store = 1'b1;
				dec.sreg_update = 1'b1;
			end
			// CP, SUB, ADC
			16'b0001_01??_????_????: begin
				dec.alu_op = avr_pkg::ALU_SUB;
				dec.sreg_update = 1'b1;
			end
			16'b0001_1???_????_????: begin
				dec.alu_op = opcode[10] ? avr_pkg::ALU_ADC : avr_pkg::ALU_SUB;
				dec.store = 1'b1;
				dec.sreg_update = 1'b1;
			end
			// AND, EOR, OR, MOV
			16'b0010_????_????_????: begin
				dec.store = 1'b1;
				dec.sreg_update = (opcode[11:10] != 2'b11);
				case (opcode[11:10])
					2'b00: dec.alu_op = avr_pkg::ALU_AND;
					2'b01: dec.alu_op = avr_pkg::ALU_EOR;
					2'b10: dec.alu_op = avr_pkg::ALU_OR;
					// MOV copies Rr through the A port
					default: dec.ra_idx = op_rr;
				endcase
			end
			// CPI, SBCI, SUBI, ORI, ANDI
			16'b0011_????_????_????,
			16'b01??_????_????_????: begin
				dec.ra_idx = op_rdi;
				dec.dest = op_rdi;
				dec.b_is_imm = 1'b1;
				dec.imm = op_k;
				dec.sreg_update = 1'b1;
				// CPI only sets flags
				dec.store = opcode[14];
				case (opcode[14:12])
					3'b100: dec.alu_op = avr_pkg::ALU_SBC;
					3'b110: dec.alu_op = avr_pkg::ALU_OR;
					3'b111: dec.alu_op = avr_pkg::ALU_AND;
					default: dec.alu_op = avr_pkg::ALU_SUB;
				endcase
			end
			// LDI
			16'b1110_????_????_????: begin
				dec.a_sel = avr_pkg::A_IMM;
				dec.imm = op_k;
				dec.dest = op_rdi;
				dec.store = 1'b1;
			end
			// LD/ST through X, plain or post-increment
			16'b1001_00??_????_110?: begin
				if (!cycle) begin
					dec.mem_write = opcode[`AVR_RR_HI];
					dec.mem_read = ~opcode[`AVR_RR_HI];
					// LD waits a cycle for the read data
					dec.next_cycle = ~opcode[`AVR_RR_HI];
					if (opcode[0]) begin
						// X + 1 goes back as a pair
						dec.x_post_inc = 1'b1;
						dec.store = 1'b1;
						dec.store_word = 1'b1;
						dec.dest = `AVR_RIDX_W'(`AVR_BASE_X);
						dec.a_sel = avr_pkg::A_X;
						dec.b_is_one = 1'b1;
						dec.alu_op = avr_pkg::ALU_ADD;
					end
				end else begin
					// Second LD cycle lands data_read in Rd
					dec.a_sel = avr_pkg::A_LOAD;
					dec.store = 1'b1;
				end
			end
			// One-operand group
			16'b1001_010?_????_0???,
			16'b1001_010?_????_1010: begin
				case (opcode[3:0])
					4'b0000: begin
						// COM as EOR 0xFF, C ends up set
						dec.alu_op = avr_pkg::ALU_EOR;
						dec.b_is_imm = 1'b1;
						dec.imm = 8'hff;
						dec.carry_one = 1'b1;
					end
					4'b0001: begin
						// NEG is 0 - Rd
						dec.alu_op = avr_pkg::ALU_SUB;
						dec.a_sel = avr_pkg::A_IMM;
						dec.rb_idx = op_rd;
					end
					4'b0011: begin
						dec.alu_op = avr_pkg::ALU_ADD;
						dec.b_is_one = 1'b1;
						dec.keep_ch = 1'b1;
					end
					4'b0101: dec.alu_op = avr_pkg::ALU_ASR;
					4'b0110: dec.alu_op = avr_pkg::ALU_LSR;
					4'b0111: dec.alu_op = avr_pkg::ALU_ROR;
					4'b1010: begin
						dec.alu_op = avr_pkg::ALU_SUB;
						dec.b_is_one = 1'b1;
						dec.keep_ch = 1'b1;
					end
					default: begin
					end
				endcase
				// SWAP and reserved slots stay as NOP
				dec.store = (dec.alu_op != avr_pkg::ALU_MOVE);
				dec.sreg_update = dec.store;
			end
			// BRBS and BRBC
			16'b1111_0???_????_????: begin
				dec.branch = 1'b1;
				dec.cond_en = 1'b1;
				dec.offset = simm7;
				dec.cond_bit = opcode[2:0];
				dec.cond_set = ~opcode[`AVR_BRBC_BIT];
			end
			// RJMP, redirect in the second cycle
			16'b1100_????_????_????: begin
				if (!cycle)
					dec.next_cycle = 1'b1;
				else begin
					dec.branch = 1'b1;
					dec.offset = simm12;
				end
			end
			default: begin
			end
		endcase
	end

endmodule

//--- rtl/avr_cpu.sv
`include "avr_consts.svh"

module avr_cpu (
	input  logic                   clk,
	input  logic                   reset,
	output logic [`AVR_ADDR_W-1:0] pc,
	input  logic [15:0]            cdata,
	output avr_pkg::data_req_t     data_req,
	input  logic [`AVR_DATA_W-1:0] data_read
);
	// Address of the instruction now on cdata
	logic [`AVR_ADDR_W-1:0] pc_q;
	logic [`AVR_ADDR_W-1:0] next_pc;
	// Set during the second cycle of LD or RJMP
	logic                   cycle_q;
	logic [15:0]            held_op;
	// Low for one bubble after reset while the first fetch settles
	logic                   fetch_valid;
	avr_pkg::sreg_t         sreg_q;
	avr_pkg::sreg_t         sreg_next;
	logic [15:0]            opcode;
	avr_pkg::decode_t       dec;
	logic [`AVR_DATA_W-1:0] rd_val;
	logic [`AVR_DATA_W-1:0] rr_val;
	logic [`AVR_ADDR_W-1:0] x_val;
	logic [`AVR_DATA_W-1:0] alu_a;
	logic [`AVR_DATA_W-1:0] alu_b;
	logic [`AVR_DATA_W-1:0] alu_result;
	avr_pkg::sreg_t         alu_sreg;
	logic                   taken;
	logic [`AVR_ADDR_W-1:0] wb_data;

	// Bubble decodes as NOP
	assign opcode = !fetch_valid ? 16'h0000 : (cycle_q ? held_op : cdata);

	avr_decode u_decode (
		.opcode (opcode),
		.cycle  (cycle_q),
		.dec    (dec)
	);

	avr_regfile u_regfile (
		.clk    (clk),
		.reset  (reset),
		.rd_idx (dec.ra_idx),
		.rr_idx (dec.rb_idx),
		.rd_val (rd_val),
		.rr_val (rr_val),
		.x_val  (x_val),
		.wen    (dec.store),
		.wword  (dec.store_word),
		.widx   (dec.dest),
		.wdata  (wb_data)
	);

	// ALU operand muxes
	always_comb begin
		case (dec.a_sel)
			avr_pkg::A_IMM:  alu_a = dec.imm;
			avr_pkg::A_LOAD: alu_a = data_read;
			avr_pkg::A_X:    alu_a = x_val[`AVR_DATA_W-1:0];
			default:         alu_a = rd_val;
		endcase
		if (dec.b_is_one)
			alu_b = `AVR_DATA_W'(1);
		else if (dec.b_is_imm)
			alu_b = dec.imm;
		else
			alu_b = rr_val;
	end

	avr_alu u_alu (
		.op       (dec.alu_op),
		.a        (alu_a),
		.b        (alu_b),
		.carry_in (sreg_q.c | dec.carry_one),
		.sreg_in  (sreg_q),
		.result   (alu_result),
		.sreg_out (alu_sreg)
	);

	always_comb begin
		sreg_next = alu_sreg;
		// INC and DEC put back the old C and H
		if (dec.keep_ch) begin
			sreg_next[`AVR_SREG_C] = sreg_q[`AVR_SREG_C];
			sreg_next[`AVR_SREG_H] = sreg_q[`AVR_SREG_H];
		end
	end

	// Pointer bump ripples the low byte carry into the high byte
	assign wb_data = dec.x_post_inc ?
		{x_val[`AVR_ADDR_W-1:`AVR_DATA_W] + `AVR_DATA_W'(alu_sreg.c), alu_result} :
		{{`AVR_DATA_W{1'b0}}, alu_result};

	// Branch test against the current flags
	assign taken = dec.branch & (~dec.cond_en | (sreg_q[dec.cond_bit] == dec.cond_set));

	always_comb begin
		if (!fetch_valid || dec.next_cycle)
			next_pc = pc_q;
		else if (taken)
			next_pc = pc_q + `AVR_ADDR_W'(1) + dec.offset;
		else
			next_pc = pc_q + `AVR_ADDR_W'(1);
	end

	// Fetch address for the next cycle
	assign pc = next_pc;

	// Only X addressing, so the address is always the pointer
	always_comb begin
		data_req.addr = x_val;
		data_req.wdata = rd_val;
		data_req.wen = dec.mem_write;
		data_req.ren = dec.mem_read;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc_q <= '0;
			cycle_q <= 1'b0;
			fetch_valid <= 1'b0;
			sreg_q <= '0;
		end else begin
			fetch_valid <= 1'b1;
			cycle_q <= dec.next_cycle;
			// Hold the PC across a second cycle
			if (!dec.next_cycle)
				pc_q <= next_pc;
			if (dec.sreg_update)
				sreg_q <= sreg_next;
		end
	end

	// Opcode replay for the second cycle
	always_ff @(posedge clk) begin
		held_op <= opcode;
	end

endmodule

//--- bench/avr_cpu_tb.sv
`include "avr_consts.svh"

module avr_cpu_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMEOUT_CYCLES = 20000;

	logic                   clk;
	logic                   reset;
	logic [`AVR_ADDR_W-1:0] pc;
	logic [15:0]            cdata;
	avr_pkg::data_req_t     data_req;
	logic [`AVR_DATA_W-1:0] data_read;

	// Program and data memory models
	logic [15:0]            prog [1024];
	logic [7:0]             dmem [1024];
	logic [15:0]            pc_s;
	avr_pkg::data_req_t     req_s;
	// Reference machine state
	logic [7:0]             ref_regs [`AVR_NREGS];
	logic [7:0]             ref_mem [1024];
	avr_pkg::sreg_t         ref_sreg;
	logic [15:0]            ref_pc;
	logic [15:0]            exp_pc [$];
	avr_pkg::data_req_t     exp_req [$];
	logic [31:0]            lfsr;
	int                     wp;
	logic                   checking;
	logic                   done;

	avr_cpu u_dut (
		.clk       (clk),
		.reset     (reset),
		.pc        (pc),
		.cdata     (cdata),
		.data_req  (data_req),
		.data_read (data_read)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_pc(input logic [`AVR_ADDR_W-1:0] exp,
		input logic [`AVR_ADDR_W-1:0] got);
		if (got !== exp)
			fail_now($sformatf("ERR %0t pc exp %h got %h", $time, exp, got));
	endtask

	task automatic check_req(input avr_pkg::data_req_t exp, input avr_pkg::data_req_t got);
		if (got.addr !== exp.addr)
			fail_now($sformatf("ERR %0t data_req.addr exp %h got %h", $time,
				exp.addr, got.addr));
		else if (got.wen !== exp.wen || got.ren !== exp.ren)
			fail_now($sformatf("ERR %0t data_req.wen/ren exp %b%b got %b%b", $time,
				exp.wen, exp.ren, got.wen, got.ren));
		// Write data only matters on a store
		else if (exp.wen && got.wdata !== exp.wdata)
			fail_now($sformatf("ERR %0t data_req.wdata exp %h got %h", $time,
				exp.wdata, got.wdata));
	endtask

	// Galois LFSR stepped once per bit
	function automatic logic lfsr_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 32'hA3000000;
		return b;
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < 8; i++)
			v = {v[6:0], lfsr_bit()};
		return v;
	endfunction

	// Fill uses all ten address bits
	function automatic logic [7:0] fill_byte(input int a);
		return 8'((a * 7) ^ (a >> 8) * 8'h5b);
	endfunction

	task automatic emit(input logic [15:0] op);
		prog[wp] = op;
		wp++;
	endtask

	// Encoders built from the AVR opcode tables
	function automatic logic [15:0] enc_rr(input logic [15:0] base, input int d, input int r);
		return base | (16'((r >> 4) & 1) << 9) | (16'(d) << 4) | 16'(r & 15);
	endfunction

	function automatic logic [15:0] enc_imm(input logic [15:0] base, input int d,
		input logic [7:0] k);
		return base | (16'(k[7:4]) << 8) | (16'(d - 16) << 4) | 16'(k[3:0]);
	endfunction

	function automatic logic [15:0] enc_br(input logic set, input int s, input int k);
		return (set ? 16'hF000 : 16'hF400) | (16'(k & 8'h7f) << 3) | 16'(s);
	endfunction

	// One stored byte per flag from C up to H via a BRBC skip
	task automatic capture_flags();
		for (int s = 0; s < 6; s++) begin
			emit(enc_imm(16'hE000, 25, 8'h00));
			emit(enc_br(1'b0, s, 1));
			emit(enc_imm(16'hE000, 25, 8'h01));
			emit(16'h920D | (16'(25) << 4));
		end
	endtask

	task automatic build_program();
		logic [15:0] rr_ops [10];
		logic [15:0] imm_ops [5];
		logic [15:0] one_ops [7];
		rr_ops = '{16'h0C00, 16'h1C00, 16'h1800, 16'h0800, 16'h2000,
			16'h2800, 16'h2400, 16'h2C00, 16'h1400, 16'h0400};
		imm_ops = '{16'h5000, 16'h4000, 16'h7000, 16'h6000, 16'h3000};
		one_ops = '{16'h9400, 16'h9401, 16'h9403, 16'h940A, 16'h9406, 16'h9405, 16'h9407};
		wp = 0;
		// LDI then ST X+ of r16..r23
		for (int d = 16; d < 24; d++)
			emit(enc_imm(16'hE000, d, rand_byte()));
		for (int d = 16; d < 24; d++)
			emit(16'h920D | (16'(d) << 4));
		// Register pairs store the result and then the flags
		foreach (rr_ops[i]) begin
			emit(enc_imm(16'hE000, 16, rand_byte()));
			emit(enc_imm(16'hE000, 17, rand_byte()));
			emit(enc_rr(rr_ops[i], 16, 17));
			emit(16'h920D | (16'(16) << 4));
			capture_flags();
		end
		foreach (imm_ops[i]) begin
			emit(enc_imm(16'hE000, 18, rand_byte()));
			emit(enc_imm(imm_ops[i], 18, rand_byte()));
			emit(16'h920D | (16'(18) << 4));
			capture_flags();
		end
		foreach (one_ops[i]) begin
			emit(enc_imm(16'hE000, 18, rand_byte()));
			emit(one_ops[i] | (16'(18) << 4));
			emit(16'h920D | (16'(18) << 4));
			capture_flags();
		end
		// Loads from the first bytes and from fill get copied to 0x300
		emit(enc_imm(16'hE000, 27, 8'h00));
		emit(enc_imm(16'hE000, 26, 8'h00));
		emit(16'h900D | (16'(20) << 4));
		emit(16'h900C | (16'(21) << 4));
		emit(16'h900D | (16'(22) << 4));
		emit(enc_imm(16'hE000, 27, 8'h03));
		emit(enc_imm(16'hE000, 26, 8'hF0));
		emit(16'h900C | (16'(23) << 4));
		emit(enc_imm(16'hE000, 26, 8'h00));
		emit(16'h920C | (16'(20) << 4));
		for (int d = 21; d < 24; d++)
			emit(16'h920D | (16'(d) << 4));
		emit(enc_rr(16'h2C00, 24, 26));
		emit(16'h920D | (16'(24) << 4));
		// Count-down loop with a backward BRBC on Z
		emit(enc_imm(16'hE000, 24, 8'h03));
		emit(16'h940A | (16'(24) << 4));
		emit(enc_br(1'b0, 1, -2));
		// BRBS taken on Z and not taken on N
		emit(enc_br(1'b1, 1, 1));
		emit(enc_imm(16'hE000, 25, 8'h55));
		emit(enc_br(1'b1, 2, 1));
		emit(enc_imm(16'hE000, 25, 8'hAA));
		emit(16'h920D | (16'(25) << 4));
		// RJMP forward, back, forward
		emit(16'hC001);
		emit(16'hC001);
		emit(16'hCFFE);
		emit(16'hCFFF);
	endtask

	function automatic void push_req(input logic [15:0] a, input logic [7:0] w,
		input logic we, input logic re);
		avr_pkg::data_req_t q;
		q.addr = a;
		q.wdata = w;
		q.wen = we;
		q.ren = re;
		exp_req.push_back(q);
	endfunction

	function automatic void set_nzs(input logic [7:0] res, input logic keep_z);
		ref_sreg.n = res[7];
		ref_sreg.z = (res == 8'h00) && (!keep_z || ref_sreg.z);
		ref_sreg.s = ref_sreg.n ^ ref_sreg.v;
	endfunction

	function automatic logic [7:0] ref_add(input logic [7:0] a, input logic [7:0] b,
		input logic c);
		int s;
		int sv;
		s = int'(a) + int'(b) + int'(c);
		sv = int'($signed(a)) + int'($signed(b)) + int'(c);
		ref_sreg.h = (int'(a & 8'h0f) + int'(b & 8'h0f) + int'(c)) > 15;
		ref_sreg.v = (sv > 127) || (sv < -128);
		ref_sreg.c = s > 255;
		set_nzs(8'(s), 1'b0);
		return 8'(s);
	endfunction

	function automatic logic [7:0] ref_sub(input logic [7:0] a, input logic [7:0] b,
		input logic c, input logic keep_z);
		int s;
		int sv;
		s = int'(a) - int'(b) - int'(c);
		sv = int'($signed(a)) - int'($signed(b)) - int'(c);
		ref_sreg.h = int'(a & 8'h0f) < int'(b & 8'h0f) + int'(c);
		ref_sreg.v = (sv > 127) || (sv < -128);
		ref_sreg.c = s < 0;
		set_nzs(8'(s), keep_z);
		return 8'(s);
	endfunction

	// One instruction on the reference machine
	function automatic void ref_step();
		logic [15:0] op;
		logic [4:0]  d;
		logic [4:0]  r;
		logic [4:0]  di;
		logic [7:0]  k;
		logic [7:0]  a;
		logic [15:0] x;
		logic [15:0] nxt;
		logic        c;
		op = prog[ref_pc[9:0]];
		d = op[8:4];
		r = {op[9], op[3:0]};
		di = {1'b1, op[7:4]};
		k = {op[11:8], op[3:0]};
		x = {ref_regs[27], ref_regs[26]};
		nxt = ref_pc + 16'd1;
		a = ref_regs[d];
		c = ref_sreg.c;
		case (op & 16'hFC00)
			16'h0C00: ref_regs[d] = ref_add(a, ref_regs[r], 1'b0);
			16'h1C00: ref_regs[d] = ref_add(a, ref_regs[r], c);
			16'h1800: ref_regs[d] = ref_sub(a, ref_regs[r], 1'b0, 1'b0);
			16'h0800: ref_regs[d] = ref_sub(a, ref_regs[r], c, 1'b1);
			16'h1400: void'(ref_sub(a, ref_regs[r], 1'b0, 1'b0));
			16'h0400: void'(ref_sub(a, ref_regs[r], c, 1'b1));
			16'h2C00: ref_regs[d] = ref_regs[r];
			16'h2000, 16'h2400, 16'h2800: begin
				// Logic ops clear V and keep C and H
				ref_regs[d] = op[11] ? (a | ref_regs[r]) :
					(op[10] ? (a ^ ref_regs[r]) : (a & ref_regs[r]));
				ref_sreg.v = 1'b0;
				set_nzs(ref_regs[d], 1'b0);
			end
			default: begin
			end
		endcase
		case (op[15:12])
			4'hE: ref_regs[di] = k;
			4'h5: ref_regs[di] = ref_sub(ref_regs[di], k, 1'b0, 1'b0);
			4'h4: ref_regs[di] = ref_sub(ref_regs[di], k, c, 1'b1);
			4'h3: void'(ref_sub(ref_regs[di], k, 1'b0, 1'b0));
			4'h7, 4'h6: begin
				ref_regs[di] = op[12] ? (ref_regs[di] & k) : (ref_regs[di] | k);
				ref_sreg.v = 1'b0;
				set_nzs(ref_regs[di], 1'b0);
			end
			default: begin
			end
		endcase
		case (op & 16'hFE0F)
			16'h9400: begin
				ref_regs[d] = ~a;
				ref_sreg.c = 1'b1;
				ref_sreg.v = 1'b0;
				set_nzs(ref_regs[d], 1'b0);
			end
			16'h9401: ref_regs[d] = ref_sub(8'h00, a, 1'b0, 1'b0);
			16'h9403, 16'h940A: begin
				// INC and DEC overflow only at the sign boundary
				ref_regs[d] = op[3] ? a - 8'd1 : a + 8'd1;
				ref_sreg.v = op[3] ? (a == 8'h80) : (a == 8'h7f);
				set_nzs(ref_regs[d], 1'b0);
			end
			16'h9405, 16'h9406, 16'h9407: begin
				ref_regs[d] = {(op[1:0] == 2'b10) ? 1'b0 : (op[1] ? c : a[7]), a[7:1]};
				ref_sreg.c = a[0];
				ref_sreg.n = ref_regs[d][7];
				ref_sreg.v = ref_sreg.n ^ ref_sreg.c;
				set_nzs(ref_regs[d], 1'b0);
			end
			16'h900C, 16'h900D: begin
				push_req(x, 8'h00, 1'b0, 1'b1);
				ref_regs[d] = ref_mem[x[9:0]];
				// LD holds the fetch address one extra cycle
				exp_pc.push_back(ref_pc);
			end
			16'h920C, 16'h920D: begin
				push_req(x, a, 1'b1, 1'b0);
				ref_mem[x[9:0]] = a;
			end
			default: begin
			end
		endcase
		if ((op & 16'hFC0E) == 16'h900C && op[0]) begin
			ref_regs[26] = 8'(x + 16'd1);
			ref_regs[27] = 8'((x + 16'd1) >> 8);
		end
		if ((op & 16'hF800) == 16'hF000 && (ref_sreg[op[2:0]] == !op[10]))
			nxt = nxt + {{9{op[9]}}, op[9:3]};
		if (op[15:12] == 4'hC) begin
			exp_pc.push_back(ref_pc);
			nxt = nxt + {{4{op[11]}}, op[11:0]};
		end
		exp_pc.push_back(nxt);
		ref_pc = nxt;
	endfunction

	task automatic run_reference();
		int steps;
		ref_pc = '0;
		ref_sreg = '0;
		steps = 0;
		foreach (ref_regs[i])
			ref_regs[i] = '0;
		// Bubble cycle right after reset
		exp_pc.push_back(16'h0000);
		while (prog[ref_pc[9:0]] != 16'hCFFF && steps < 4000) begin
			ref_step();
			steps++;
		end
		ref_step();
	endtask

	// Sample where outputs are stable and check them
	always @(negedge clk) begin
		pc_s = pc;
		req_s = data_req;
		if (checking) begin
			if (exp_pc.size() > 0)
				check_pc(exp_pc.pop_front(), pc);
			else
				done = 1'b1;
			if (data_req.wen || data_req.ren) begin
				if (exp_req.size() == 0)
					fail_now("Data strobe fired with no access expected");
				else
					check_req(exp_req.pop_front(), data_req);
			end
		end
	end

	// Memories answer 1 ns after the edge
	always @(posedge clk) begin
		#1;
		cdata = prog[pc_s[9:0]];
		if (req_s.wen === 1'b1)
			dmem[req_s.addr[9:0]] = req_s.wdata;
		if (req_s.ren === 1'b1)
			data_read = dmem[req_s.addr[9:0]];
	end

	initial begin
		reset = 1'b1;
		cdata = '0;
		data_read = '0;
		checking = 1'b0;
		done = 1'b0;
		pc_s = '0;
		req_s = '0;
		lfsr = 32'h90bdc061;
		foreach (prog[i])
			prog[i] = '0;
		foreach (dmem[i]) begin
			dmem[i] = fill_byte(i);
			ref_mem[i] = fill_byte(i);
		end
		build_program();
		run_reference();
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;
		checking = 1'b1;
		for (int i = 0; i < TIMEOUT_CYCLES && !done; i++)
			@(posedge clk);
		if (!done) begin
			fail_now("Timeout waiting for the expected PC sequence to finish");
		end else if (exp_req.size() != 0) begin
			fail_now($sformatf("%0d expected data accesses never happened", exp_req.size()));
		end else begin
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule

//--- build.f
+incdir+common
common/avr_pkg.sv
rtl/avr_alu.sv
rtl/avr_regfile.sv
decode/avr_decode.sv
rtl/avr_cpu.sv
bench/avr_cpu_tb.sv

//--- Makefile
# Verilator flow for the AVR core and its testbench

VERILATOR ?= verilator
TB_TOP    ?= avr_cpu_tb
RTL_TOP   ?= avr_cpu
FLIST     ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@grep -q "PASS: all tests" $(LOG) || { echo "Simulation did not finish"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
